// ==== all.f ====
+incdir+bench
rtl/tp_fixed_pkg.sv
rtl/tp_flow_pkg.sv
rtl/operand_sequencer.sv
rtl/pair_fifo.sv
rtl/product_store.sv
rtl/tensor_product.sv
bench/tb_tensor_product.sv

// ==== bench/tp_checks.svh ====
`ifndef TP_CHECKS_SVH
`define TP_CHECKS_SVH

//////////////////////////////////////////////////
// Reference model
//////////////////////////////////////////////////

// Expected result cell for one a/b pair
// Product, floor division by the fraction scale, clamp to the result range
function automatic result_cell_t ref_cell(input cell_t x, input cell_t y);
    int scale;
    int prod;
    int quo;
    scale = 1 << FRACTION_WIDTH;
    prod  = int'(x) * int'(y);
    quo   = prod / scale;
    // Integer divide truncates toward zero
    // Step down once more for negative inexact quotients
    if ((prod < 0) && (prod % scale != 0))
        quo = quo - 1;
    if (quo > RESULT_MAX)
        quo = RESULT_MAX;
    else if (quo < RESULT_MIN)
        quo = RESULT_MIN;
    return result_cell_t'(quo);
endfunction

//////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////

// One result cell against its expected value
task automatic check_cell(input string name, input result_cell_t expected,
                          input result_cell_t actual);
    if (actual !== expected)
        stop_with_failure($sformatf("CHECK FAILED %s: expected %0d, actual %0d",
                                    name, expected, actual));
endtask

// One status flag, valid or busy
task automatic check_flag(input string name, input bit expected, input bit actual);
    if (actual !== expected)
        stop_with_failure($sformatf("CHECK FAILED %s: expected %0b, actual %0b",
                                    name, expected, actual));
endtask

`endif

// ==== bench/tb_tensor_product.sv ====
module tb_tensor_product
    import tp_fixed_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int A_LEN       = 5;
    localparam int B_LEN       = 5;
    localparam int FIFO_DEPTH  = 4;
    localparam int CELLS       = A_LEN * B_LEN;
    localparam int CLK_PERIOD  = 40;
    // Reference, saturation, 20 random and the busy test
    localparam int JOB_COUNT   = 23;
    // Generous bound on cycles per pair through the three links
    localparam int PAIR_CYCLES = 12;
    localparam int MARGIN_NS   = 20000;
    localparam int WATCHDOG_NS = JOB_COUNT * CELLS * PAIR_CYCLES * CLK_PERIOD + MARGIN_NS;

    typedef cell_t [A_LEN-1:0]        a_vec_t;
    typedef cell_t [B_LEN-1:0]        b_vec_t;
    typedef result_cell_t [CELLS-1:0] matrix_t;

    logic    clk = 1'b0;
    logic    reset;
    logic    start;
    a_vec_t  a;
    b_vec_t  b;
    matrix_t result;
    logic    valid;
    logic    busy;

    // Job bookkeeping shared by stimulus and comparator
    int      seed          = 12;
    int      jobs_launched = 0;
    int      jobs_checked  = 0;
    string   job_name      = "reset";
    matrix_t exp_matrix;

    // Reports the reason and ends the run
    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    `include "tp_checks.svh"

    tensor_top #(
        .A_LEN      (A_LEN),
        .B_LEN      (B_LEN),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut (
        .clk    (clk),
        .reset  (reset),
        .start  (start),
        .a      (a),
        .b      (b),
        .result (result),
        .valid  (valid),
        .busy   (busy)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////////////////////////
    // Job helpers
    //////////////////////////////////////////////////

    // Drives one start pulse and records the expected matrix
    task automatic launch_job(input string name, input a_vec_t va, input b_vec_t vb);
        @(negedge clk);
        a        = va;
        b        = vb;
        start    = 1'b1;
        job_name = name;
        for (int i = 0; i < A_LEN; i++) begin
            for (int j = 0; j < B_LEN; j++) begin
                exp_matrix[i*B_LEN+j] = ref_cell(va[i], vb[j]);
            end
        end
        jobs_launched++;
        @(negedge clk);
        start = 1'b0;
        // Busy follows one cycle after the accepted start
        check_flag({name, " busy after start"}, 1'b1, busy);
    endtask

    // Blocks until the comparator has seen this job through
    task automatic await_check();
        wait (jobs_checked == jobs_launched);
    endtask

    task automatic run_job(input string name, input a_vec_t va, input b_vec_t vb);
        launch_job(name, va, vb);
        await_check();
    endtask

    //////////////////////////////////////////////////
    // Comparator
    //////////////////////////////////////////////////

    initial begin : compare_results
        forever begin
            wait (jobs_checked < jobs_launched);
            // Old matrix drops valid first, then the new one raises it
            @(negedge clk);
            while (valid)
                @(negedge clk);
            while (!valid)
                @(negedge clk);
            for (int i = 0; i < A_LEN; i++) begin
                for (int j = 0; j < B_LEN; j++) begin
                    check_cell($sformatf("%s cell (%0d,%0d)", job_name, i, j),
                               exp_matrix[i*B_LEN+j], result[i*B_LEN+j]);
                end
            end
            // Busy falls in the same cycle as valid rises
            check_flag({job_name, " busy at valid"}, 1'b0, busy);
            // Valid holds past the job until the next one writes
            @(negedge clk);
            check_flag({job_name, " valid at end"}, 1'b1, valid);
            jobs_checked++;
        end
    end

    //////////////////////////////////////////////////
    // Watchdog
    //////////////////////////////////////////////////

    initial begin : watchdog
        #(WATCHDOG_NS);
        stop_with_failure($sformatf("Timeout after %0d ns: valid never came for job %s",
                                    WATCHDOG_NS, job_name));
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial begin : stimulus
        a_vec_t va;
        b_vec_t vb;
        reset = 1'b1;
        start = 1'b0;
        a     = '0;
        b     = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Idle state after reset
        check_flag("reset valid", 1'b0, valid);
        check_flag("reset busy", 1'b0, busy);
        for (int k = 0; k < CELLS; k++)
            check_cell($sformatf("reset cell %0d", k), '0, result[k]);

        // Reference vectors with index 0 as the rightmost item
        va = {cell_t'(-50), cell_t'(40), cell_t'(30), cell_t'(20), cell_t'(10)};
        vb = {cell_t'(1), cell_t'(2), cell_t'(-3), cell_t'(4), cell_t'(5)};
        run_job("reference", va, vb);

        // Extremes on both sides of the clamp
        va = {cell_t'(3), cell_t'(-128), cell_t'(127), cell_t'(-128), cell_t'(127)};
        vb = {cell_t'(2), cell_t'(-128), cell_t'(127), cell_t'(127), cell_t'(-128)};
        run_job("saturation", va, vb);

        for (int n = 0; n < 20; n++) begin
            for (int i = 0; i < A_LEN; i++)
                va[i] = cell_t'($random(seed));
            for (int j = 0; j < B_LEN; j++)
                vb[j] = cell_t'($random(seed));
            run_job($sformatf("random %0d", n), va, vb);
        end

        // Second start mid job must not disturb the latched vectors
        va = {cell_t'(9), cell_t'(-7), cell_t'(5), cell_t'(-3), cell_t'(1)};
        vb = {cell_t'(-2), cell_t'(4), cell_t'(-6), cell_t'(8), cell_t'(-10)};
        launch_job("start while busy", va, vb);
        repeat (3) @(negedge clk);
        a     = ~va;
        b     = ~vb;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_flag("start while busy still busy", 1'b1, busy);
        await_check();

        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== rtl/operand_sequencer.sv ====
// Operand sequencer
// Latches both vectors on start and offers every (row, col) pair
// in row-major order over a four-phase req/ack link
module operand_sequencer
    import tp_fixed_pkg::*, tp_flow_pkg::*;
#(
    parameter int A_LEN = 5,
    parameter int B_LEN = 5
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  cell_t [A_LEN-1:0]  a,
    input  cell_t [B_LEN-1:0]  b,
    input  logic               job_done,
    output logic               busy,
    output logic               seq_req,
    input  logic               seq_ack,
    output pair_t              seq_pair
);

    localparam idx_t ROW_LAST = idx_t'(A_LEN - 1);
    localparam idx_t COL_LAST = idx_t'(B_LEN - 1);

    seq_state_t        state;
    logic              busy_q;
    idx_t              row;
    idx_t              col;
    cell_t [A_LEN-1:0] a_q;
    cell_t [B_LEN-1:0] b_q;
    cell_t             a_sel;
    cell_t             b_sel;
    logic              accept;
    logic              last_pair;

    // Busy drops together with job_done, so a new start is taken right away
    assign busy   = busy_q & ~job_done;
    assign accept = start & ~busy;

    assign last_pair = (row == ROW_LAST) && (col == COL_LAST);

    //////////////////////////////////////////////////
    // Operand latch
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (accept) begin
            a_q <= a;
            b_q <= b;
        end
    end

    // Cell select by index
    always_comb begin
        a_sel = '0;
        for (int i = 0; i < A_LEN; i++) begin
            if (row == idx_t'(i))
                a_sel = a_q[i];
        end
        b_sel = '0;
        for (int j = 0; j < B_LEN; j++) begin
            if (col == idx_t'(j))
                b_sel = b_q[j];
        end
    end

    //////////////////////////////////////////////////
    // Handshake FSM and index counters
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= SEQ_IDLE;
            busy_q <= 1'b0;
            row    <= '0;
            col    <= '0;
        end else if (accept) begin
            // New job starts at pair (0, 0)
            state  <= SEQ_OFFER;
            busy_q <= 1'b1;
            row    <= '0;
            col    <= '0;
        end else begin
            if (job_done)
                busy_q <= 1'b0;
            case (state)
                SEQ_OFFER: begin
                    // Receiver took the pair
                    if (seq_ack)
                        state <= SEQ_RELEASE;
                end
                SEQ_RELEASE: begin
                    // Next req only after ack has fallen
                    if (!seq_ack) begin
                        if (last_pair) begin
                            state <= SEQ_IDLE;
                        end else begin
                            state <= SEQ_OFFER;
                            if (col == COL_LAST) begin
                                col <= '0;
                                row <= row + idx_t'(1);
                            end else begin
                                col <= col + idx_t'(1);
                            end
                        end
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    assign seq_req  = (state == SEQ_OFFER);
    assign seq_pair = '{row: row, col: col, a_cell: a_sel, b_cell: b_sel};

    //////////////////////////////////////////////////
    // Link checks
    //////////////////////////////////////////////////

    // Pair held while offered
    assert property (@(posedge clk) disable iff (reset)
        seq_req && $past(seq_req) |-> $stable(seq_pair));

    // Four-phase rule, no new req over a pending ack
    assert property (@(posedge clk) disable iff (reset)
        $rose(seq_req) |-> !seq_ack);

endmodule

// ==== rtl/pair_fifo.sv ====
// Pair queue between the sequencer and the product store
// Four-phase slave on the write side, four-phase master on the read side
module pair_fifo
    import tp_flow_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  seq_req,
    output logic  seq_ack,
    input  pair_t seq_pair,
    output logic  fifo_req,
    input  logic  fifo_ack,
    output pair_t fifo_pair
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(FIFO_DEPTH - 1);
    localparam logic [CNT_W-1:0] DEPTH_C  = CNT_W'(FIFO_DEPTH);

    pair_t            mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    //////////////////////////////////////////////////
    // Write engine on the slave side
    //////////////////////////////////////////////////

    // Take a pair on a fresh req when there is room
    // A full queue keeps ack low and the sequencer just waits
    assign push = seq_req && !seq_ack && (count < DEPTH_C);

    always_ff @(posedge clk) begin
        if (reset) begin
            seq_ack <= 1'b0;
        end else if (push) begin
            seq_ack <= 1'b1;
        end else if (seq_ack && !seq_req) begin
            // Sender released so the cycle ends
            seq_ack <= 1'b0;
        end
    end

    // Storage written on the ack edge
    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= seq_pair;
    end

    //////////////////////////////////////////////////
    // Read engine on the master side
    //////////////////////////////////////////////////

    // Head entry done once the store acknowledges it
    assign pop = fifo_req && fifo_ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            fifo_req <= 1'b0;
        end else if (pop) begin
            fifo_req <= 1'b0;
        end else if (!fifo_req && !fifo_ack && (count != '0)) begin
            // Previous ack gone, offer the next head
            fifo_req <= 1'b1;
        end
    end

    // Head stays put until the pop
    assign fifo_pair = mem[rd_ptr];

    //////////////////////////////////////////////////
    // Pointers and fill count
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    // Fill level within depth and in step with the pointer distance
    assert property (@(posedge clk) disable iff (reset)
        (count <= DEPTH_C) &&
        ((wr_ptr == rd_ptr) == ((count == '0) || (count == DEPTH_C))));

endmodule

// ==== rtl/product_store.sv ====
// Product store
// Takes pairs from the FIFO, forms the rescaled and saturated product
// and writes it into the result matrix
module product_store
    import tp_fixed_pkg::*, tp_flow_pkg::*;
#(
    parameter int A_LEN = 5,
    parameter int B_LEN = 5
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             fifo_req,
    output logic                             fifo_ack,
    input  pair_t                            fifo_pair,
    output result_cell_t [A_LEN*B_LEN-1:0]   result,
    output logic                             valid,
    output logic                             job_done
);

    localparam idx_t ROW_LAST = idx_t'(A_LEN - 1);
    localparam idx_t COL_LAST = idx_t'(B_LEN - 1);

    // Limits in product width for the clamp
    localparam product_t SAT_HI = product_t'(RESULT_MAX);
    localparam product_t SAT_LO = product_t'(RESULT_MIN);

    store_state_t state;
    pair_t        pair_q;
    product_t     product;
    product_t     shifted;
    result_cell_t sat_cell;
    logic         capture;
    logic         first_pair;
    logic         last_pair;

    assign capture = (state == ST_WAIT_REQ) && fifo_req;

    // Captured pair, payload only
    always_ff @(posedge clk) begin
        if (capture)
            pair_q <= fifo_pair;
    end

    //////////////////////////////////////////////////
    // Arithmetic
    //////////////////////////////////////////////////

    // Signed 8x8 multiply, full 16 bit result
    assign product = product_t'(pair_q.a_cell) * product_t'(pair_q.b_cell);

    // Drop one set of fraction bits
    // Arithmetic shift floors toward minus infinity
    assign shifted = product >>> FRACTION_WIDTH;

    // Clamp to the result range
    always_comb begin
        if (shifted > SAT_HI)
            sat_cell = result_cell_t'(RESULT_MAX);
        else if (shifted < SAT_LO)
            sat_cell = result_cell_t'(RESULT_MIN);
        else
            sat_cell = result_cell_t'(shifted);
    end

    // Job boundaries from the pair position
    assign first_pair = (pair_q.row == '0) && (pair_q.col == '0);
    assign last_pair  = (pair_q.row == ROW_LAST) && (pair_q.col == COL_LAST);

    //////////////////////////////////////////////////
    // Handshake FSM and result matrix
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ST_WAIT_REQ;
            fifo_ack <= 1'b0;
            valid    <= 1'b0;
            job_done <= 1'b0;
            result   <= '0;
        end else begin
            // One cycle pulse
            job_done <= 1'b0;
            case (state)
                ST_WAIT_REQ: begin
                    if (fifo_req) begin
                        fifo_ack <= 1'b1;
                        state    <= ST_COMPUTE;
                    end
                end
                ST_COMPUTE: begin
                    // Cell (i, j) lives at slot i*B_LEN + j
                    for (int i = 0; i < A_LEN; i++) begin
                        for (int j = 0; j < B_LEN; j++) begin
                            if (pair_q.row == idx_t'(i) && pair_q.col == idx_t'(j))
                                result[i*B_LEN+j] <= sat_cell;
                        end
                    end
                    // Old matrix no longer valid
                    if (first_pair)
                        valid <= 1'b0;
                    // Whole matrix written
                    if (last_pair) begin
                        valid    <= 1'b1;
                        job_done <= 1'b1;
                    end
                    state <= ST_WAIT_DROP;
                end
                ST_WAIT_DROP: begin
                    // Hold ack until the FIFO lets go of req
                    if (!fifo_req) begin
                        fifo_ack <= 1'b0;
                        state    <= ST_WAIT_REQ;
                    end
                end
                default: state <= ST_WAIT_REQ;
            endcase
        end
    end

    // Indices from the sequencer stay inside the matrix
    assert property (@(posedge clk) disable iff (reset)
        capture |-> (int'(fifo_pair.row) < A_LEN) && (int'(fifo_pair.col) < B_LEN));

endmodule

// ==== rtl/tensor_product.sv ====
// Outer product of two fixed-point vectors
// Sequencer -> pair FIFO -> product store, four-phase links in between
module tensor_top
    import tp_fixed_pkg::*, tp_flow_pkg::*;
#(
    parameter int A_LEN      = 5,
    parameter int B_LEN      = 5,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           start,
    input  cell_t [A_LEN-1:0]              a,
    input  cell_t [B_LEN-1:0]              b,
    output result_cell_t [A_LEN*B_LEN-1:0] result,
    output logic                           valid,
    output logic                           busy
);

    //////////////////////////////////////////////////
    // Inner links
    //////////////////////////////////////////////////

    // Sequencer to FIFO
    logic  seq_req;
    logic  seq_ack;
    pair_t seq_pair;

    // FIFO to store
    logic  fifo_req;
    logic  fifo_ack;
    pair_t fifo_pair;

    // Store back to sequencer
    logic  job_done;

    //////////////////////////////////////////////////
    // Blocks
    //////////////////////////////////////////////////

    operand_sequencer #(
        .A_LEN (A_LEN),
        .B_LEN (B_LEN)
    ) u_sequencer (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .a        (a),
        .b        (b),
        .job_done (job_done),
        .busy     (busy),
        .seq_req  (seq_req),
        .seq_ack  (seq_ack),
        .seq_pair (seq_pair)
    );

    pair_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .reset     (reset),
        .seq_req   (seq_req),
        .seq_ack   (seq_ack),
        .seq_pair  (seq_pair),
        .fifo_req  (fifo_req),
        .fifo_ack  (fifo_ack),
        .fifo_pair (fifo_pair)
    );

    product_store #(
        .A_LEN (A_LEN),
        .B_LEN (B_LEN)
    ) u_store (
        .clk       (clk),
        .reset     (reset),
        .fifo_req  (fifo_req),
        .fifo_ack  (fifo_ack),
        .fifo_pair (fifo_pair),
        .result    (result),
        .valid     (valid),
        .job_done  (job_done)
    );

endmodule

// ==== rtl/tp_fixed_pkg.sv ====
// Fixed-point number formats of the outer product datapath
package tp_fixed_pkg;

    //////////////////////////////////////////////////
    // Operand cells
    //////////////////////////////////////////////////

    // Width of one a or b cell
    localparam int CELL_WIDTH = 8;

    // Fraction bits of a and b, result keeps the same count
    localparam int FRACTION_WIDTH = 1;

    // Signed operand cell
    typedef logic signed [CELL_WIDTH-1:0] cell_t;

    //////////////////////////////////////////////////
    // Products and result cells
    //////////////////////////////////////////////////

    // Full precision product of two cells
    localparam int PRODUCT_WIDTH = 2 * CELL_WIDTH;

    // Raw product before rescale
    typedef logic signed [PRODUCT_WIDTH-1:0] product_t;

    // Width of one cell of the result matrix
    localparam int RESULT_WIDTH = 12;

    // Signed result cell
    typedef logic signed [RESULT_WIDTH-1:0] result_cell_t;

    // Saturation limits of result_cell_t
    // 2047 and -2048 for a 12 bit cell
    localparam int RESULT_MAX = (1 << (RESULT_WIDTH - 1)) - 1;
    localparam int RESULT_MIN = -(1 << (RESULT_WIDTH - 1));

endpackage

// ==== rtl/tp_flow_pkg.sv ====
// Transfer and control types shared by the sequencer, FIFO and store
package tp_flow_pkg;

    import tp_fixed_pkg::*;

    //////////////////////////////////////////////////
    // Pair transfer
    //////////////////////////////////////////////////

    // Row or column index, vectors up to 16 cells
    localparam int IDX_WIDTH = 4;
    typedef logic [IDX_WIDTH-1:0] idx_t;

    // One a/b cell pair with its matrix position, 24 bits
    typedef struct packed {
        idx_t  row;     // index into a
        idx_t  col;     // index into b
        cell_t a_cell;
        cell_t b_cell;
    } pair_t;

    //////////////////////////////////////////////////
    // Control FSMs
    //////////////////////////////////////////////////

    // Operand sequencer
    typedef enum logic [1:0] {
        SEQ_IDLE,       // waiting for start or done
        SEQ_OFFER,      // req high, pair on the bus
        SEQ_RELEASE     // req low, waiting for ack to fall
    } seq_state_t;

    // Product store
    typedef enum logic [1:0] {
        ST_WAIT_REQ,    // idle, watching fifo_req
        ST_COMPUTE,     // pair captured, write cell
        ST_WAIT_DROP    // ack high until req falls
    } store_state_t;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the tensor product testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f all.f \
    --top-module tb_tensor_product \
    -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

sim_out=$(./obj_dir/tb_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "Done: no errors"; then
    exit 0
fi
echo "Pass message not found"
exit 1
